/* frontend_pkg.sv */
package frontend_pkg;

    // address width and reset fetch address
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] INIT_PC = 32'h8000_0000;

    // fetch block geometry
    localparam int BLOCK_BYTES = 16;
    // byte offset bits inside one block, the ftb index starts above them
    localparam int BLOCK_OFS_W = $clog2(BLOCK_BYTES);

    // ftb geometry, index is pc[7:4] and tag is pc[15:8]
    localparam int FTB_ENTRIES = 16;
    localparam int FTB_IDX_W = 4;
    localparam int FTB_TAG_W = 8;

    // fall-through offset in bytes, 1 to 16
    localparam int OFS_W = 5;

    // 2-bit counter, upper half predicts taken
    localparam int CTR_W = 2;
    localparam logic [CTR_W-1:0] CTR_TAKEN_MIN = 2'd2;

    // branch types kept in an ftb entry
    localparam int BR_TYPE_W = 2;
    localparam logic [BR_TYPE_W-1:0] BR_NONE = 2'd0;
    localparam logic [BR_TYPE_W-1:0] BR_COND = 2'd1;
    localparam logic [BR_TYPE_W-1:0] BR_JUMP = 2'd2;
    localparam logic [BR_TYPE_W-1:0] BR_CALL = 2'd3;

    // fetch target queue
    localparam int FTQ_DEPTH = 4;
    localparam int FTQ_PTR_W = $clog2(FTQ_DEPTH);

    // first byte after the predicted block
    function automatic logic [XLEN-1:0] calc_fallthru(
        input logic [XLEN-1:0] start,
        input logic [OFS_W-1:0] ofs
    );
        return start + XLEN'(ofs);
    endfunction

    // entries hold the full target, no offset encoding
    function automatic logic [XLEN-1:0] calc_target(
        input logic [XLEN-1:0] target
    );
        return target;
    endfunction

    // next fetch address after a block that hit in the ftb
    function automatic logic [XLEN-1:0] calc_npc(
        input logic [XLEN-1:0] start,
        input logic taken,
        input logic [OFS_W-1:0] ofs,
        input logic [XLEN-1:0] target
    );
        return taken ? calc_target(target) : calc_fallthru(start, ofs);
    endfunction

endpackage

/* ftb.sv */
`timescale 1ns/1ns

module ftb (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_squash_vld,
    input  logic [frontend_pkg::XLEN-1:0]      i_lookup_pc,
    input  logic                               i_update_vld,
    input  logic [frontend_pkg::XLEN-1:0]      i_update_pc,
    input  logic [frontend_pkg::BR_TYPE_W-1:0] i_update_br_type,
    input  logic [frontend_pkg::CTR_W-1:0]     i_update_ctr,
    input  logic [frontend_pkg::OFS_W-1:0]     i_update_ofs,
    input  logic [frontend_pkg::XLEN-1:0]      i_update_target,
    output logic                               o_lookup_gnt,
    output logic                               o_lookup_hit,
    output logic                               o_lookup_hit_rdy,
    output logic [frontend_pkg::BR_TYPE_W-1:0] o_lookup_br_type,
    output logic [frontend_pkg::CTR_W-1:0]     o_lookup_ctr,
    output logic [frontend_pkg::OFS_W-1:0]     o_lookup_ofs,
    output logic [frontend_pkg::XLEN-1:0]      o_lookup_target,
    output logic                               o_update_finished
);
    import frontend_pkg::*;

    // entry storage, one slot per pc[7:4]
    logic [FTB_ENTRIES-1:0] valid_q;
    logic [FTB_TAG_W-1:0]   tag_q     [FTB_ENTRIES];
    logic [BR_TYPE_W-1:0]   br_type_q [FTB_ENTRIES];
    logic [CTR_W-1:0]       ctr_q     [FTB_ENTRIES];
    logic [OFS_W-1:0]       ofs_q     [FTB_ENTRIES];
    logic [XLEN-1:0]        target_q  [FTB_ENTRIES];

    logic                 upd_seen;
    logic                 wr_en;
    logic [FTB_IDX_W-1:0] wr_idx;
    logic [FTB_TAG_W-1:0] wr_tag;

    logic                 s1_gnt;
    logic [FTB_IDX_W-1:0] s1_idx;
    logic [FTB_TAG_W-1:0] s1_tag;

    // write only on the first cycle of an update level
    assign wr_en  = i_update_vld && !upd_seen;
    assign wr_idx = i_update_pc[BLOCK_OFS_W +: FTB_IDX_W];
    assign wr_tag = i_update_pc[BLOCK_OFS_W + FTB_IDX_W +: FTB_TAG_W];

    // no lookup is granted while an update is in flight
    assign o_lookup_gnt = !i_update_vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q           <= '0;
            upd_seen          <= 1'b0;
            o_update_finished <= 1'b0;
        end else begin
            upd_seen          <= i_update_vld;
            o_update_finished <= wr_en;
            // any write makes the slot valid
            if (wr_en) begin
                valid_q[wr_idx] <= 1'b1;
            end
        end
    end

    // whole entry replaced on a write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]     <= wr_tag;
            br_type_q[wr_idx] <= i_update_br_type;
            ctr_q[wr_idx]     <= i_update_ctr;
            ofs_q[wr_idx]     <= i_update_ofs;
            target_q[wr_idx]  <= i_update_target;
        end
    end

    // stage one
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_gnt <= 1'b0;
        end else if (i_squash_vld) begin
            s1_gnt <= 1'b0;
        end else begin
            s1_gnt <= o_lookup_gnt;
        end
    end

    always_ff @(posedge clk) begin
        s1_idx <= i_lookup_pc[BLOCK_OFS_W +: FTB_IDX_W];
        s1_tag <= i_lookup_pc[BLOCK_OFS_W + FTB_IDX_W +: FTB_TAG_W];
    end

    // tag compare on the registered lookup
    assign o_lookup_hit     = valid_q[s1_idx] && (tag_q[s1_idx] == s1_tag);
    assign o_lookup_hit_rdy = s1_gnt;

    // stage two, entry fields one cycle behind the hit
    always_ff @(posedge clk) begin
        o_lookup_br_type <= br_type_q[s1_idx];
        o_lookup_ctr     <= ctr_q[s1_idx];
        o_lookup_ofs     <= ofs_q[s1_idx];
        o_lookup_target  <= target_q[s1_idx];
    end

endmodule

/* bpu.sv */
`timescale 1ns/1ns

module bpu (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_squash_vld,
    input  logic [frontend_pkg::XLEN-1:0]      i_squash_pc,
    input  logic                               i_update_vld,
    input  logic [frontend_pkg::XLEN-1:0]      i_update_pc,
    input  logic [frontend_pkg::BR_TYPE_W-1:0] i_update_br_type,
    input  logic [frontend_pkg::CTR_W-1:0]     i_update_ctr,
    input  logic [frontend_pkg::OFS_W-1:0]     i_update_ofs,
    input  logic [frontend_pkg::XLEN-1:0]      i_update_target,
    output logic                               o_update_finished,
    input  logic                               i_ftq_rdy,
    output logic                               o_pred_vld,
    output logic [frontend_pkg::XLEN-1:0]      o_pred_start,
    output logic [frontend_pkg::XLEN-1:0]      o_pred_end,
    output logic                               o_pred_taken,
    output logic [frontend_pkg::XLEN-1:0]      o_pred_target,
    output logic                               o_pred_hit,
    output logic [frontend_pkg::CTR_W-1:0]     o_pred_ctr
);
    import frontend_pkg::*;

    logic [XLEN-1:0]  base_pc, s1_pc, s2_pc, s2_seq_fallthru, lookup_pc;
    logic             pred_continue, redirect, squash_vld;
    logic             lookup_gnt, ftb_s1_hit, ftb_s1_rdy;
    logic [CTR_W-1:0] ftb_s2_ctr;
    logic [OFS_W-1:0] ftb_s2_ofs;
    logic [XLEN-1:0]  ftb_s2_target;

    // copies of the ftb outputs taken on the first stalled edge
    logic             held, h1_hit, h1_rdy;
    logic [CTR_W-1:0] h2_ctr;
    logic [OFS_W-1:0] h2_ofs;
    logic [XLEN-1:0]  h2_target;

    logic             s1_hit, s1_rdy;
    logic [CTR_W-1:0] s2_ctr;
    logic [OFS_W-1:0] s2_ofs;
    logic [XLEN-1:0]  s2_target, s2_npc;
    logic             s2_hit, s2_hit_rdy, s2_use, s2_taken;

    // the only stall is a full ftq under a waiting prediction
    assign pred_continue = !o_pred_vld || i_ftq_rdy;
    // a hit redirects once its block has left for the ftq
    assign redirect      = s2_use && pred_continue;
    assign squash_vld    = i_squash_vld || redirect;
    // keep the ftb stage one on the frozen s1 block while stalled
    assign lookup_pc     = pred_continue ? base_pc : s1_pc;

    ftb ftb_i (
        .clk              (clk),
        .rst              (rst),
        .i_squash_vld     (squash_vld),
        .i_lookup_pc      (lookup_pc),
        .i_update_vld     (i_update_vld),
        .i_update_pc      (i_update_pc),
        .i_update_br_type (i_update_br_type),
        .i_update_ctr     (i_update_ctr),
        .i_update_ofs     (i_update_ofs),
        .i_update_target  (i_update_target),
        .o_lookup_gnt     (lookup_gnt),
        .o_lookup_hit     (ftb_s1_hit),
        .o_lookup_hit_rdy (ftb_s1_rdy),
        .o_lookup_br_type (),
        .o_lookup_ctr     (ftb_s2_ctr),
        .o_lookup_ofs     (ftb_s2_ofs),
        .o_lookup_target  (ftb_s2_target),
        .o_update_finished(o_update_finished)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            held   <= 1'b0;
            h1_hit <= 1'b0;
            h1_rdy <= 1'b0;
        end else begin
            held <= !(squash_vld || pred_continue);
            if (!held) begin
                h1_hit <= ftb_s1_hit;
                h1_rdy <= ftb_s1_rdy;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!held) begin
            h2_ctr    <= ftb_s2_ctr;
            h2_ofs    <= ftb_s2_ofs;
            h2_target <= ftb_s2_target;
        end
    end

    assign s1_hit    = held ? h1_hit    : ftb_s1_hit;
    assign s1_rdy    = held ? h1_rdy    : ftb_s1_rdy;
    assign s2_ctr    = held ? h2_ctr    : ftb_s2_ctr;
    assign s2_ofs    = held ? h2_ofs    : ftb_s2_ofs;
    assign s2_target = held ? h2_target : ftb_s2_target;

    // s2 flags, cleared by either squash source
    always_ff @(posedge clk) begin
        if (rst || squash_vld) begin
            s2_use     <= 1'b0;
            s2_hit     <= 1'b0;
            s2_hit_rdy <= 1'b0;
        end else if (pred_continue) begin
            s2_use     <= s1_rdy && s1_hit;
            s2_hit     <= s1_hit;
            s2_hit_rdy <= s1_rdy;
        end
    end

    // next fetch address, backend first
    always_ff @(posedge clk) begin
        if (rst) begin
            base_pc <= INIT_PC;
        end else if (i_squash_vld) begin
            base_pc <= i_squash_pc;
        end else if (redirect) begin
            base_pc <= s2_npc;
        end else if (pred_continue && lookup_gnt) begin
            // an ungranted lookup leaves base_pc to be issued again
            base_pc <= base_pc + XLEN'(BLOCK_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (pred_continue) begin
            s1_pc           <= base_pc;
            s2_pc           <= s1_pc;
            s2_seq_fallthru <= s1_pc + XLEN'(BLOCK_BYTES);
        end
    end

    assign s2_taken = s2_use && (s2_ctr >= CTR_TAKEN_MIN);
    assign s2_npc   = calc_npc(s2_pc, s2_taken, s2_ofs, s2_target);

    assign o_pred_vld    = s2_hit_rdy;
    assign o_pred_start  = s2_pc;
    assign o_pred_end    = s2_use ? calc_fallthru(s2_pc, s2_ofs) - 1'b1
                                  : s2_seq_fallthru - 1'b1;
    assign o_pred_taken  = s2_taken;
    // a miss reports the sequential successor as its target
    assign o_pred_target = s2_use ? calc_target(s2_target) : s2_seq_fallthru;
    assign o_pred_hit    = s2_hit;
    assign o_pred_ctr    = s2_use ? s2_ctr : CTR_W'(1);

endmodule

/* ftq.sv */
`timescale 1ns/1ns

module ftq (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_flush,
    input  logic                           i_enq_vld,
    input  logic [frontend_pkg::XLEN-1:0]  i_pred_start,
    input  logic [frontend_pkg::XLEN-1:0]  i_pred_end,
    input  logic                           i_pred_taken,
    input  logic [frontend_pkg::XLEN-1:0]  i_pred_target,
    input  logic                           i_pred_hit,
    input  logic [frontend_pkg::CTR_W-1:0] i_pred_ctr,
    output logic                           o_enq_rdy,
    output logic                           o_deq_vld,
    input  logic                           i_deq_rdy,
    output logic [frontend_pkg::XLEN-1:0]  o_fetch_start,
    output logic [frontend_pkg::XLEN-1:0]  o_fetch_end,
    output logic                           o_fetch_taken,
    output logic [frontend_pkg::XLEN-1:0]  o_fetch_target,
    output logic                           o_fetch_hit,
    output logic [frontend_pkg::CTR_W-1:0] o_fetch_ctr
);
    import frontend_pkg::*;

    logic [XLEN-1:0]  start_q  [FTQ_DEPTH];
    logic [XLEN-1:0]  end_q    [FTQ_DEPTH];
    logic             taken_q  [FTQ_DEPTH];
    logic [XLEN-1:0]  target_q [FTQ_DEPTH];
    logic             hit_q    [FTQ_DEPTH];
    logic [CTR_W-1:0] ctr_q    [FTQ_DEPTH];

    logic [FTQ_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [FTQ_PTR_W:0]   count;
    logic                 enq, deq;

    assign o_enq_rdy = (count < FTQ_DEPTH);
    assign o_deq_vld = (count != '0);
    // a write in the flush cycle is dropped
    assign enq = i_enq_vld && o_enq_rdy && !i_flush;
    assign deq = o_deq_vld && i_deq_rdy;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // depth is a power of two so the pointers wrap by themselves
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (FTQ_PTR_W + 1)'(enq) - (FTQ_PTR_W + 1)'(deq);
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            start_q[wr_ptr]  <= i_pred_start;
            end_q[wr_ptr]    <= i_pred_end;
            taken_q[wr_ptr]  <= i_pred_taken;
            target_q[wr_ptr] <= i_pred_target;
            hit_q[wr_ptr]    <= i_pred_hit;
            ctr_q[wr_ptr]    <= i_pred_ctr;
        end
    end

    // head entry straight out of the array
    assign o_fetch_start  = start_q[rd_ptr];
    assign o_fetch_end    = end_q[rd_ptr];
    assign o_fetch_taken  = taken_q[rd_ptr];
    assign o_fetch_target = target_q[rd_ptr];
    assign o_fetch_hit    = hit_q[rd_ptr];
    assign o_fetch_ctr    = ctr_q[rd_ptr];

endmodule

/* frontend_top.sv */
`timescale 1ns/1ns

module frontend_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_squash_vld,
    input  logic [frontend_pkg::XLEN-1:0]      i_squash_pc,
    input  logic                               i_update_vld,
    input  logic [frontend_pkg::XLEN-1:0]      i_update_pc,
    input  logic [frontend_pkg::BR_TYPE_W-1:0] i_update_br_type,
    input  logic [frontend_pkg::CTR_W-1:0]     i_update_ctr,
    input  logic [frontend_pkg::OFS_W-1:0]     i_update_ofs,
    input  logic [frontend_pkg::XLEN-1:0]      i_update_target,
    output logic                               o_update_finished,
    output logic                               o_fetch_vld,
    input  logic                               i_fetch_rdy,
    output logic [frontend_pkg::XLEN-1:0]      o_fetch_start,
    output logic [frontend_pkg::XLEN-1:0]      o_fetch_end,
    output logic                               o_fetch_taken,
    output logic [frontend_pkg::XLEN-1:0]      o_fetch_target,
    output logic                               o_fetch_hit,
    output logic [frontend_pkg::CTR_W-1:0]     o_fetch_ctr
);
    import frontend_pkg::*;

    // prediction strobe from bpu into the ftq
    logic             pred_vld, ftq_rdy, pred_taken, pred_hit;
    logic [XLEN-1:0]  pred_start, pred_end, pred_target;
    logic [CTR_W-1:0] pred_ctr;

    bpu bpu_i (
        .clk              (clk),
        .rst              (rst),
        .i_squash_vld     (i_squash_vld),
        .i_squash_pc      (i_squash_pc),
        .i_update_vld     (i_update_vld),
        .i_update_pc      (i_update_pc),
        .i_update_br_type (i_update_br_type),
        .i_update_ctr     (i_update_ctr),
        .i_update_ofs     (i_update_ofs),
        .i_update_target  (i_update_target),
        .o_update_finished(o_update_finished),
        .i_ftq_rdy        (ftq_rdy),
        .o_pred_vld       (pred_vld),
        .o_pred_start     (pred_start),
        .o_pred_end       (pred_end),
        .o_pred_taken     (pred_taken),
        .o_pred_target    (pred_target),
        .o_pred_hit       (pred_hit),
        .o_pred_ctr       (pred_ctr)
    );

    // only the backend squash empties the queue
    ftq ftq_i (
        .clk           (clk),
        .rst           (rst),
        .i_flush       (i_squash_vld),
        .i_enq_vld     (pred_vld),
        .i_pred_start  (pred_start),
        .i_pred_end    (pred_end),
        .i_pred_taken  (pred_taken),
        .i_pred_target (pred_target),
        .i_pred_hit    (pred_hit),
        .i_pred_ctr    (pred_ctr),
        .o_enq_rdy     (ftq_rdy),
        .o_deq_vld     (o_fetch_vld),
        .i_deq_rdy     (i_fetch_rdy),
        .o_fetch_start (o_fetch_start),
        .o_fetch_end   (o_fetch_end),
        .o_fetch_taken (o_fetch_taken),
        .o_fetch_target(o_fetch_target),
        .o_fetch_hit   (o_fetch_hit),
        .o_fetch_ctr   (o_fetch_ctr)
    );

endmodule

/* tb_frontend.sv */
`timescale 1ns/1ns

module tb_frontend;
    import frontend_pkg::*;

    localparam int MAX_REC = 64;

    logic                 clk;
    logic                 rst;
    logic                 i_squash_vld;
    logic [XLEN-1:0]      i_squash_pc;
    logic                 i_update_vld;
    logic [XLEN-1:0]      i_update_pc;
    logic [BR_TYPE_W-1:0] i_update_br_type;
    logic [CTR_W-1:0]     i_update_ctr;
    logic [OFS_W-1:0]     i_update_ofs;
    logic [XLEN-1:0]      i_update_target;
    logic                 o_update_finished;
    logic                 o_fetch_vld;
    logic                 i_fetch_rdy;
    logic [XLEN-1:0]      o_fetch_start;
    logic [XLEN-1:0]      o_fetch_end;
    logic                 o_fetch_taken;
    logic [XLEN-1:0]      o_fetch_target;
    logic                 o_fetch_hit;
    logic [CTR_W-1:0]     o_fetch_ctr;

    // one letter per record plus up to six hex fields
    byte             rec_kind [MAX_REC];
    logic [XLEN-1:0] rec_f    [MAX_REC][6];
    int              rec_cnt;

    int     mismatches;
    int     other_errs;
    int     cycle_cnt;
    int     limit = 100;
    integer seed;

    frontend_top dut_i (
        .clk              (clk),
        .rst              (rst),
        .i_squash_vld     (i_squash_vld),
        .i_squash_pc      (i_squash_pc),
        .i_update_vld     (i_update_vld),
        .i_update_pc      (i_update_pc),
        .i_update_br_type (i_update_br_type),
        .i_update_ctr     (i_update_ctr),
        .i_update_ofs     (i_update_ofs),
        .i_update_target  (i_update_target),
        .o_update_finished(o_update_finished),
        .o_fetch_vld      (o_fetch_vld),
        .i_fetch_rdy      (i_fetch_rdy),
        .o_fetch_start    (o_fetch_start),
        .o_fetch_end      (o_fetch_end),
        .o_fetch_taken    (o_fetch_taken),
        .o_fetch_target   (o_fetch_target),
        .o_fetch_hit      (o_fetch_hit),
        .o_fetch_ctr      (o_fetch_ctr)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic load_trace();
        int              fd;
        int              k;
        string           line;
        byte             kind;
        logic [XLEN-1:0] f0, f1, f2, f3, f4, f5;
        rec_cnt = 0;
        fd = $fopen("frontend_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open frontend_trace.txt for reading");
            other_errs++;
        end else begin
            while (!$feof(fd) && rec_cnt < MAX_REC) begin
                line = "";
                void'($fgets(line, fd));
                kind = (line.len() > 1) ? line.getc(0) : "#";
                // comment and blank lines carry no record
                if (kind == "U" || kind == "S" || kind == "E") begin
                    f0 = '0;
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    f4 = '0;
                    f5 = '0;
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                                  f0, f1, f2, f3, f4, f5));
                    rec_kind[rec_cnt] = kind;
                    rec_f[rec_cnt][0] = f0;
                    rec_f[rec_cnt][1] = f1;
                    rec_f[rec_cnt][2] = f2;
                    rec_f[rec_cnt][3] = f3;
                    rec_f[rec_cnt][4] = f4;
                    rec_f[rec_cnt][5] = f5;
                    rec_cnt++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ftb write while the fetch side is held off
    task automatic apply_update(input int idx);
        int waited;
        @(negedge clk);
        i_fetch_rdy      = 1'b0;
        i_update_pc      = rec_f[idx][0];
        i_update_br_type = rec_f[idx][1][BR_TYPE_W-1:0];
        i_update_ctr     = rec_f[idx][2][CTR_W-1:0];
        i_update_ofs     = rec_f[idx][3][OFS_W-1:0];
        i_update_target  = rec_f[idx][4];
        i_update_vld     = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!o_update_finished);
        // the finish pulse comes one cycle after the level rises
        check_field("o_update_finished latency", 1, waited);
        i_update_vld = 1'b0;
    endtask

    task automatic apply_squash(input int idx);
        @(negedge clk);
        i_fetch_rdy  = 1'b0;
        i_squash_vld = 1'b1;
        i_squash_pc  = rec_f[idx][0];
        @(negedge clk);
        i_squash_vld = 1'b0;
    endtask

    // random ready until one block is taken, then compare it
    task automatic expect_block(input int idx);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            i_fetch_rdy = (($random(seed) & 3) != 0);
            accepted = o_fetch_vld && i_fetch_rdy;
        end
        check_field("o_fetch_start", rec_f[idx][0], o_fetch_start);
        check_field("o_fetch_end", rec_f[idx][1], o_fetch_end);
        check_field("o_fetch_taken", rec_f[idx][2], XLEN'(o_fetch_taken));
        check_field("o_fetch_target", rec_f[idx][3], o_fetch_target);
        check_field("o_fetch_hit", rec_f[idx][4], XLEN'(o_fetch_hit));
        check_field("o_fetch_ctr", rec_f[idx][5], XLEN'(o_fetch_ctr));
    endtask

    task automatic print_counts();
        $display("error counts: %0d value mismatches, %0d other errors", mismatches, other_errs);
    endtask

    initial begin
        int i;
        seed             = 32'hf2cc;
        mismatches       = 0;
        other_errs       = 0;
        rst              = 1'b1;
        i_squash_vld     = 1'b0;
        i_squash_pc      = '0;
        i_update_vld     = 1'b0;
        i_update_pc      = '0;
        i_update_br_type = '0;
        i_update_ctr     = '0;
        i_update_ofs     = '0;
        i_update_target  = '0;
        i_fetch_rdy      = 1'b0;
        load_trace();
        limit = 100 + 50 * rec_cnt;
        repeat (4) @(posedge clk);
        @(negedge clk);
        // nothing may be queued out of reset
        check_field("o_fetch_vld", 0, XLEN'(o_fetch_vld));
        check_field("o_update_finished", 0, XLEN'(o_update_finished));
        rst = 1'b0;
        for (i = 0; i < rec_cnt; i++) begin
            case (rec_kind[i])
                "U": apply_update(i);
                "S": apply_squash(i);
                default: expect_block(i);
            endcase
        end
        @(negedge clk);
        i_fetch_rdy = 1'b0;
        print_counts();
        if (mismatches == 0 && other_errs == 0 && rec_cnt > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog on the trace length
    initial begin
        cycle_cnt = 0;
        @(posedge clk);
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the run hung before the trace ended", cycle_cnt);
        other_errs++;
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

/* frontend_trace.txt */
# U pc br_type ctr ofs target | S pc | E start end taken target hit ctr
# every field in hex, one record per line
U 80000080 2 3 08 80000208
U 80000208 1 1 0c 80000400
E 80000000 8000000f 0 80000010 0 1
E 80000010 8000001f 0 80000020 0 1
E 80000020 8000002f 0 80000030 0 1
E 80000030 8000003f 0 80000040 0 1
E 80000040 8000004f 0 80000050 0 1
E 80000050 8000005f 0 80000060 0 1
E 80000060 8000006f 0 80000070 0 1
E 80000070 8000007f 0 80000080 0 1
E 80000080 80000087 1 80000208 1 3
E 80000208 80000213 0 80000400 1 1
E 80000214 80000223 0 80000224 0 1
E 80000224 80000233 0 80000234 0 1
S 80001000
E 80001000 8000100f 0 80001010 0 1
E 80001010 8000101f 0 80001020 0 1
U 80000080 3 2 04 80000300
S 80000060
E 80000060 8000006f 0 80000070 0 1
E 80000070 8000007f 0 80000080 0 1
E 80000080 80000083 1 80000300 1 2
E 80000300 8000030f 0 80000310 0 1

/* verilog.f */
frontend_pkg.sv
ftb.sv
bpu.sv
ftq.sv
frontend_top.sv
tb_frontend.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert -Wno-fatal
TOP      := tb_frontend
FILELIST := verilog.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Simulation passed
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the trace is read relative to the project root
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
